//--- Makefile
# Verilator build and run for the byte field unit

VERILATOR  ?= verilator
TOP        ?= byte_field_tb
RTL_TOP    ?= byte_field_unit
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --timing --assert
PASS_TEXT  ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -Mdir $(OBJ_DIR) \
		--top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass message
run: build
	@out=$$(./$(SIM_BIN)); status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		common/byte_pkg.sv shifter/byte_rotator.sv shifter/mask_gen.sv \
		logic/byte_decode.sv logic/byte_masker.sv logic/byte_field_unit.sv

clean:
	rm -rf $(OBJ_DIR)

//--- common/byte_pkg.sv
/* Byte field unit shared definitions */

package byte_pkg;

   // Word and field geometry
   localparam int word_w = 32;        // Data word
   localparam int pos_w  = 5;         // Bit position or width code

   // Field operations
   typedef enum logic [1:0] {
      OP_LDB    = 2'd0,               // Extract and right-justify
      OP_DPB    = 2'd1,               // Move low field up and deposit
      OP_SELDEP = 2'd2,               // Deposit in place
      OP_ROT    = 2'd3                // Rotate only
   } byte_op_e;

endpackage

//--- logic/byte_decode.sv
/* Byte field decode stage */

module byte_decode (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  byte_pkg::byte_op_e          op,
   input  logic [byte_pkg::pos_w-1:0]  pos,
   input  logic [byte_pkg::pos_w-1:0]  width_m1,
   input  logic [byte_pkg::word_w-1:0] m_data,
   input  logic [byte_pkg::word_w-1:0] a_data,
   output logic                        s1_valid,
   input  logic                        s1_ready,
   output logic [byte_pkg::word_w-1:0] s1_m,
   output logic [byte_pkg::word_w-1:0] s1_a,
   output logic [byte_pkg::pos_w-1:0]  s1_rot,
   output logic [byte_pkg::pos_w-1:0]  s1_left,
   output logic [byte_pkg::pos_w-1:0]  s1_right
);

   localparam int pos_w = byte_pkg::pos_w;

   logic             accept;
   logic [pos_w:0]   left_sum;       // Carry flags overflow past bit 31
   logic [pos_w-1:0] left_sat;
   logic [pos_w-1:0] rot_d;
   logic [pos_w-1:0] left_d;
   logic [pos_w-1:0] right_d;

   assign in_ready = !s1_valid || s1_ready;
   assign accept   = in_valid && in_ready;

   assign left_sum = {1'b0, pos} + {1'b0, width_m1};
   assign left_sat = left_sum[pos_w] ? '1 : left_sum[pos_w-1:0];

   always_comb begin
      case (op)
         byte_pkg::OP_LDB: begin
            rot_d   = pos_w'(0) - pos;   // Rotate right by pos
            right_d = '0;
            left_d  = width_m1;
         end
         byte_pkg::OP_DPB: begin
            rot_d   = pos;
            right_d = pos;
            left_d  = left_sat;
         end
         byte_pkg::OP_SELDEP: begin
            rot_d   = '0;                // Bits stay in place
            right_d = pos;
            left_d  = left_sat;
         end
         default: begin
            rot_d   = pos;
            right_d = '0;
            left_d  = '1;                // Whole word
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
      end else if (in_ready) begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         s1_m     <= m_data;
         s1_a     <= a_data;
         s1_rot   <= rot_d;
         s1_left  <= left_d;
         s1_right <= right_d;
      end
   end

endmodule

//--- logic/byte_field_unit.sv
/* Byte field unit */

module byte_field_unit (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  byte_pkg::byte_op_e          op,
   input  logic [byte_pkg::pos_w-1:0]  pos,
   input  logic [byte_pkg::pos_w-1:0]  width_m1,
   input  logic [byte_pkg::word_w-1:0] m_data,
   input  logic [byte_pkg::word_w-1:0] a_data,
   output logic                        out_valid,
   input  logic                        out_ready,
   output logic [byte_pkg::word_w-1:0] result
);

   logic                        s1_valid;
   logic                        s1_ready;
   logic [byte_pkg::word_w-1:0] s1_m;
   logic [byte_pkg::word_w-1:0] s1_a;
   logic [byte_pkg::pos_w-1:0]  s1_rot;
   logic [byte_pkg::pos_w-1:0]  s1_left;
   logic [byte_pkg::pos_w-1:0]  s1_right;
   logic [byte_pkg::word_w-1:0] rotated;
   logic [byte_pkg::word_w-1:0] mask;

   byte_decode i_byte_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .op       (op),
      .pos      (pos),
      .width_m1 (width_m1),
      .m_data   (m_data),
      .a_data   (a_data),
      .s1_valid (s1_valid),
      .s1_ready (s1_ready),
      .s1_m     (s1_m),
      .s1_a     (s1_a),
      .s1_rot   (s1_rot),
      .s1_left  (s1_left),
      .s1_right (s1_right)
   );

   byte_rotator i_byte_rotator (
      .m      (s1_m),
      .amount (s1_rot),
      .r      (rotated)
   );

   mask_gen i_mask_gen (
      .left  (s1_left),
      .right (s1_right),
      .mask  (mask)
   );

   byte_masker i_byte_masker (
      .clk       (clk),
      .arst_n    (arst_n),
      .s1_valid  (s1_valid),
      .s1_ready  (s1_ready),
      .rotated   (rotated),
      .mask      (mask),
      .a         (s1_a),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .result    (result)
   );

endmodule

//--- logic/byte_masker.sv
/* Byte field merge stage */

module byte_masker (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        s1_valid,
   output logic                        s1_ready,
   input  logic [byte_pkg::word_w-1:0] rotated,
   input  logic [byte_pkg::word_w-1:0] mask,
   input  logic [byte_pkg::word_w-1:0] a,
   input  logic                        out_ready,
   output logic                        out_valid,
   output logic [byte_pkg::word_w-1:0] result
);

   logic [byte_pkg::word_w-1:0] merged;
   logic                        load;

   // Output register free or draining this cycle
   assign s1_ready = !out_valid || out_ready;
   assign load     = s1_valid && s1_ready;

   // Rotated bits inside the field, A outside
   assign merged = (rotated & mask) | (a & ~mask);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (s1_ready) begin
         out_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         result <= merged;   // Holds while out_ready is low
      end
   end

endmodule

//--- project.f
common/byte_pkg.sv
shifter/byte_rotator.sv
shifter/mask_gen.sv
logic/byte_decode.sv
logic/byte_masker.sv
logic/byte_field_unit.sv
verification/byte_field_props.sv
verification/byte_field_tb.sv

//--- shifter/byte_rotator.sv
/* Two-level word rotator */

module byte_rotator (
   input  logic [byte_pkg::word_w-1:0] m,
   input  logic [byte_pkg::pos_w-1:0]  amount,
   output logic [byte_pkg::word_w-1:0] r
);

   localparam int word_w = byte_pkg::word_w;
   localparam int pos_w  = byte_pkg::pos_w;
   localparam int lanes  = 4;                  // Bits per nibble step
   localparam int nib_n  = word_w / lanes;     // Nibble positions per lane

   logic [word_w-1:0] sa;                      // After fine stage

   // Fine stage, 0 to 3 bits
   always_comb begin
      case (amount[1:0])
         2'd0:    sa = m;
         2'd1:    sa = {m[word_w-2:0], m[word_w-1]};
         2'd2:    sa = {m[word_w-3:0], m[word_w-1:word_w-2]};
         default: sa = {m[word_w-4:0], m[word_w-1:word_w-3]};
      endcase
   end

   // Coarse stage moves each lane by whole nibbles
   always_comb begin : coarse
      logic [nib_n-1:0]   lane;
      logic [2*nib_n-1:0] lane_dbl;
      r = '0;
      for (int j = 0; j < lanes; j++) begin
         for (int k = 0; k < nib_n; k++) begin
            lane[k] = sa[lanes*k + j];         // Bits sharing position mod 4
         end
         lane_dbl = {lane, lane} << amount[pos_w-1:2];
         for (int k = 0; k < nib_n; k++) begin
            r[lanes*k + j] = lane_dbl[nib_n + k];  // Upper half is the rotated lane
         end
      end
   end

endmodule

//--- shifter/mask_gen.sv
/* Field mask generator */

module mask_gen (
   input  logic [byte_pkg::pos_w-1:0]  left,
   input  logic [byte_pkg::pos_w-1:0]  right,
   output logic [byte_pkg::word_w-1:0] mask
);

   localparam logic [byte_pkg::word_w-1:0] all_ones = '1;

   logic [byte_pkg::word_w-1:0] left_mask;   // Bits 0 up to left
   logic [byte_pkg::word_w-1:0] right_mask;  // Bits right up to 31

   // ~left is 31 minus left in five bits
   assign left_mask  = all_ones >> (~left);
   assign right_mask = all_ones << right;

   // Empty when right lies above left
   assign mask = left_mask & right_mask;

endmodule

//--- verification/byte_field_props.sv
/* Byte field handshake properties */

module byte_field_props (
   input logic                        clk,
   input logic                        arst_n,
   input logic                        in_valid,
   input logic                        in_ready,
   input byte_pkg::byte_op_e          op,
   input logic [byte_pkg::pos_w-1:0]  pos,
   input logic [byte_pkg::pos_w-1:0]  width_m1,
   input logic [byte_pkg::word_w-1:0] m_data,
   input logic [byte_pkg::word_w-1:0] a_data,
   input logic                        out_valid,
   input logic                        out_ready,
   input logic [byte_pkg::word_w-1:0] result,
   input logic                        s1_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   // Stalled request holds
   assert property (@(posedge clk) disable iff (!arst_n)
      in_valid && !in_ready |=> in_valid && $stable({op, pos, width_m1, m_data, a_data}))
      else $error("input request changed before it was accepted");

   // Stalled result holds
   assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(result))
      else $error("output result changed before it was taken");

   assert property (@(posedge clk) $rose(arst_n) |-> !out_valid ##1 !out_valid)
      else $error("out_valid high right after reset");

   // Either empty stage lets a request in
   assert property (@(posedge clk) disable iff (!arst_n) !s1_valid || !out_valid |-> in_ready)
      else $error("in_ready low while a pipeline stage is empty");

endmodule

bind byte_field_unit byte_field_props i_byte_field_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .op        (op),
   .pos       (pos),
   .width_m1  (width_m1),
   .m_data    (m_data),
   .a_data    (a_data),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .result    (result),
   .s1_valid  (s1_valid)
);

//--- verification/byte_field_tb.sv
/* Byte field unit testbench */

module byte_field_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int word_w      = byte_pkg::word_w;
   localparam int pos_w       = byte_pkg::pos_w;
   localparam int send_limit  = 100;      // Cycles to wait for in_ready
   localparam int drain_limit = 300;      // Cycles to wait for results

   logic               clk = 1'b0;
   logic               arst_n;
   logic               in_valid;
   logic               in_ready;
   byte_pkg::byte_op_e op;
   logic [pos_w-1:0]   pos;
   logic [pos_w-1:0]   width_m1;
   logic [word_w-1:0]  m_data;
   logic [word_w-1:0]  a_data;
   logic               out_valid;
   logic               out_ready;
   logic [word_w-1:0]  result;

   integer             seed = 32'h6a4c_c68c;
   int                 errors = 0;
   int                 checks = 0;
   logic               bp_mode;            // Toggle out_ready when set
   logic [word_w-1:0]  exp_q[$];           // Expected results in order
   logic               held_ok = 1'b0;
   logic [word_w-1:0]  held_word;

   byte_field_unit i_byte_field_unit (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .op        (op),
      .pos       (pos),
      .width_m1  (width_m1),
      .m_data    (m_data),
      .a_data    (a_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result)
   );

   always #5 clk = ~clk;

   always @(negedge clk) begin
      out_ready = bp_mode ? 1'($random(seed)) : 1'b1;
   end

   function automatic logic [word_w-1:0] rotate_left(input logic [word_w-1:0] w, input int n);
      logic [word_w-1:0] r;
      for (int i = 0; i < word_w; i++) begin
         r[(i + n) % word_w] = w[i];
      end
      return r;
   endfunction

   // Operation level model of the field rules
   function automatic logic [word_w-1:0] model_result(input byte_pkg::byte_op_e o,
         input logic [pos_w-1:0] p, input logic [pos_w-1:0] w,
         input logic [word_w-1:0] m, input logic [word_w-1:0] a);
      int                rot;
      int                lo;
      int                hi;
      logic [word_w-1:0] rm;
      logic [word_w-1:0] res;
      rot = int'(p);
      lo  = int'(p);
      hi  = int'(p) + int'(w);
      if (hi > word_w - 1) hi = word_w - 1;     // Saturate at bit 31
      case (o)
         byte_pkg::OP_LDB: begin
            rot = (word_w - int'(p)) % word_w;
            lo  = 0;
            hi  = int'(w);
         end
         byte_pkg::OP_SELDEP: rot = 0;
         byte_pkg::OP_ROT: begin
            lo = 0;
            hi = word_w - 1;
         end
         default: ;
      endcase
      rm = rotate_left(m, rot);
      for (int i = 0; i < word_w; i++) begin
         res[i] = (i >= lo && i <= hi) ? rm[i] : a[i];
      end
      return res;
   endfunction

   task automatic check_word(input string name, input logic [word_w-1:0] got,
         input logic [word_w-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Scoreboard, sampled on the rising edge before the DUT updates
   always @(posedge clk) begin
      if (arst_n) begin
         check_bit("in_ready", in_ready, (exp_q.size() < 2) || out_ready);
         if (held_ok && out_valid) check_word("result", result, held_word);
         held_ok   = out_valid && !out_ready;
         held_word = result;
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Output transfer with no request outstanding at %0t", $time);
            end else begin
               check_word("result", result, exp_q.pop_front());
            end
         end
         if (in_valid && in_ready) begin
            exp_q.push_back(model_result(op, pos, width_m1, m_data, a_data));
         end
      end
   end

   function automatic logic [word_w-1:0] rnd_word();
      return $random(seed);
   endfunction

   task automatic send(input byte_pkg::byte_op_e o, input logic [pos_w-1:0] p,
         input logic [pos_w-1:0] w, input logic [word_w-1:0] m, input logic [word_w-1:0] a);
      int   n;
      logic taken;
      @(negedge clk);
      in_valid = 1'b1;
      op       = o;
      pos      = p;
      width_m1 = w;
      m_data   = m;
      a_data   = a;
      n        = 0;
      taken    = 1'b0;
      while (!taken && n < send_limit) begin
         @(posedge clk);
         taken = in_ready;
         n++;
      end
      if (!taken) begin
         errors++;
         $display("Timeout: request was never accepted at %0t", $time);
      end
   endtask

   task automatic idle();
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < drain_limit) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Timeout: %0d results never arrived", exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic test_reset();
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b1);
   endtask

   task automatic test_rot();
      for (int p = 0; p < word_w; p++) begin
         send(byte_pkg::OP_ROT, pos_w'(p), pos_w'($random(seed)), rnd_word(), rnd_word());
      end
      idle();
      wait_drain();
   endtask

   task automatic test_ldb();
      send(byte_pkg::OP_LDB, 5'd0, 5'd31, rnd_word(), rnd_word());    // Width 32
      send(byte_pkg::OP_LDB, 5'd28, 5'd7, rnd_word(), rnd_word());    // Crosses bit 31
      send(byte_pkg::OP_LDB, 5'd31, 5'd31, rnd_word(), rnd_word());
      for (int i = 0; i < 24; i++) begin
         send(byte_pkg::OP_LDB, pos_w'($random(seed)), pos_w'($random(seed)),
              rnd_word(), rnd_word());
      end
      idle();
      wait_drain();
   endtask

   task automatic test_deposit();
      for (int k = 0; k < 2; k++) begin
         byte_pkg::byte_op_e o;
         o = (k == 0) ? byte_pkg::OP_DPB : byte_pkg::OP_SELDEP;
         send(o, 5'd28, 5'd7, rnd_word(), rnd_word());    // Saturates
         send(o, 5'd31, 5'd31, rnd_word(), rnd_word());
         send(o, 5'd0, 5'd31, rnd_word(), rnd_word());
         send(o, 5'd16, 5'd20, rnd_word(), rnd_word());
         for (int i = 0; i < 20; i++) begin
            send(o, pos_w'($random(seed)), pos_w'($random(seed)), rnd_word(), rnd_word());
         end
      end
      idle();
      wait_drain();
   endtask

   task automatic test_stream();
      bp_mode = 1'b1;
      for (int i = 0; i < 80; i++) begin
         send(byte_pkg::byte_op_e'(2'($random(seed))), pos_w'($random(seed)),
              pos_w'($random(seed)), rnd_word(), rnd_word());
      end
      idle();
      wait_drain();
      bp_mode = 1'b0;
      idle();
   endtask

   task automatic test_latency();
      repeat (2) idle();
      send(byte_pkg::OP_DPB, 5'd8, 5'd7, rnd_word(), rnd_word());
      idle();
      @(posedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      @(posedge clk);
      check_bit("out_valid", out_valid, 1'b1);   // Second edge after acceptance
      wait_drain();
   endtask

   initial begin
      arst_n   = 1'b0;
      in_valid = 1'b0;
      op       = byte_pkg::OP_LDB;
      pos      = '0;
      width_m1 = '0;
      m_data   = '0;
      a_data   = '0;
      bp_mode  = 1'b0;
      out_ready = 1'b1;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      test_reset();
      test_rot();
      test_ldb();
      test_deposit();
      test_stream();
      test_latency();
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
